/* lane_pkg.sv */
package lane_pkg;

    // ----------------------------------------------------------
    // Lane dimensions
    // ----------------------------------------------------------
    localparam int num_engines = 4;
    localparam int engine_id_w = 2;
    localparam int data_w      = 32;
    localparam int hop_w       = 4;
    localparam int payload_w   = 40;

    // Every top-level FIFO shares these
    localparam int fifo_depth             = 16;
    localparam int fifo_almost_full_level = 12;

    // Per-engine count of requests still waiting for a response
    localparam int outstanding_w = 5;

    // ----------------------------------------------------------
    // Packet payload, one 40-bit word read two ways
    // ----------------------------------------------------------
    typedef struct packed {
        logic [engine_id_w-1:0]                          target;
        logic [hop_w-1:0]                                hop;
        logic [payload_w-engine_id_w-hop_w-data_w-1:0]   spare;
        logic [data_w-1:0]                               data;
    } lane_view_t;

    typedef struct packed {
        logic [engine_id_w-1:0]                  engine_id;
        logic [payload_w-engine_id_w-data_w-1:0] spare;
        logic [data_w-1:0]                       addr;
    } mem_view_t;

    // Lane traffic uses the lane view, requests and responses the memory view
    typedef union packed {
        lane_view_t lane;
        mem_view_t  mem;
    } packet_payload_u;

endpackage

/* sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter int depth = lane_pkg::fifo_depth
) (
    input  logic                      ap_clk,
    input  logic                      areset_lane_template,
    input  logic                      wr_en_i,
    input  lane_pkg::packet_payload_u din_i,
    input  logic                      rd_en_i,
    output lane_pkg::packet_payload_u dout_o,
    output logic                      valid_o,
    output logic                      empty_o,
    output logic                      full_o,
    output logic                      almost_full_o
);

    // Pointers wrap naturally, so depth is a power of two
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    // Two-entry buffers stop accepting at one entry, one item is always in flight
    localparam int af_level = (depth == lane_pkg::fifo_depth) ?
                              lane_pkg::fifo_almost_full_level : depth - 1;

    lane_pkg::packet_payload_u ram [depth];
    logic [ptr_w-1:0]          wr_ptr;
    logic [ptr_w-1:0]          rd_ptr;
    logic [cnt_w-1:0]          count;
    logic                      wr_ok;
    logic                      rd_ok;

    assign wr_ok = wr_en_i & ~full_o;
    assign rd_ok = rd_en_i & ~empty_o;

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            ram[wr_ptr] <= din_i;
        end
        if (rd_ok) begin
            dout_o <= ram[rd_ptr];
        end
    end

    assign empty_o       = (count == '0);
    assign full_o        = (count == cnt_w'(depth));
    assign almost_full_o = (count >= cnt_w'(af_level));

endmodule

/* lane_engine.sv */
`timescale 1ns/1ns

module lane_engine #(
    parameter int engine_index = 0
) (
    input  logic                      ap_clk,
    input  logic                      areset_lane_template,
    input  logic                      in_valid_i,
    input  lane_pkg::packet_payload_u in_payload_i,
    output logic                      in_almost_full_o,
    input  logic                      down_almost_full_i,
    output logic                      out_valid_o,
    output lane_pkg::packet_payload_u out_payload_o,
    output logic                      req_valid_o,
    output lane_pkg::packet_payload_u req_payload_o,
    input  logic                      req_pop_i,
    input  logic                      resp_valid_i,
    output logic                      idle_o
);

    lane_pkg::packet_payload_u          lane_dout;
    logic                               lane_valid;
    logic                               lane_empty;
    logic                               lane_pop;
    lane_pkg::packet_payload_u          req_din;
    logic                               req_push;
    logic                               req_empty;
    logic                               req_almost_full;
    logic                               target_hit;
    logic [lane_pkg::outstanding_w-1:0] outstanding;

    // ----------------------------------------------------------
    // Lane path
    // ----------------------------------------------------------
    // Head is held while either the next stage or the request buffer lacks room
    assign lane_pop = ~lane_empty & ~down_almost_full_i & ~req_almost_full;

    sync_fifo #(
        .depth(2)
    ) u_lane_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (in_valid_i),
        .din_i               (in_payload_i),
        .rd_en_i             (lane_pop),
        .dout_o              (lane_dout),
        .valid_o             (lane_valid),
        .empty_o             (lane_empty),
        .full_o              (),
        .almost_full_o       (in_almost_full_o)
    );

    // Hop count bumped on the way out of the buffer
    always_comb begin
        out_payload_o          = lane_dout;
        out_payload_o.lane.hop = lane_dout.lane.hop + 1'b1;
    end

    assign out_valid_o = lane_valid;

    // ----------------------------------------------------------
    // Memory request path
    // ----------------------------------------------------------
    assign target_hit = (lane_dout.lane.target == lane_pkg::engine_id_w'(engine_index));
    assign req_push   = lane_valid & target_hit;

    always_comb begin
        req_din.mem.engine_id = lane_dout.lane.target;
        req_din.mem.spare     = '0;
        req_din.mem.addr      = lane_dout.lane.data;
    end

    // Payload shows up on req_payload_o the cycle after the grant pops it
    sync_fifo #(
        .depth(2)
    ) u_req_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_en_i             (req_push),
        .din_i               (req_din),
        .rd_en_i             (req_pop_i),
        .dout_o              (req_payload_o),
        .valid_o             (),
        .empty_o             (req_empty),
        .full_o              (),
        .almost_full_o       (req_almost_full)
    );

    assign req_valid_o = ~req_empty;

    // Outstanding requests, counted from the push until the response strobe
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            outstanding <= '0;
        end else begin
            case ({req_push, resp_valid_i})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign idle_o = (outstanding == '0);

endmodule

/* mem_request_arbiter.sv */
`timescale 1ns/1ns

module mem_request_arbiter (
    input  logic                                ap_clk,
    input  logic                                areset_lane_template,
    input  logic [lane_pkg::num_engines-1:0]    req_valid_i,
    input  lane_pkg::packet_payload_u           req_payload_i [lane_pkg::num_engines],
    output logic [lane_pkg::num_engines-1:0]    grant_o,
    input  logic                                out_almost_full_i,
    output logic                                out_valid_o,
    output lane_pkg::packet_payload_u           out_payload_o
);

    logic [lane_pkg::engine_id_w-1:0] rr_ptr;
    logic [lane_pkg::engine_id_w-1:0] winner;
    logic [lane_pkg::engine_id_w-1:0] winner_q;
    logic [lane_pkg::engine_id_w-1:0] idx;
    logic                             found;

    // Search from the pointer upward; the index wraps since num_engines is 2**engine_id_w
    always_comb begin
        winner = rr_ptr;
        found  = 1'b0;
        idx    = rr_ptr;
        for (int k = lane_pkg::num_engines - 1; k >= 0; k--) begin
            idx = rr_ptr + lane_pkg::engine_id_w'(k);
            if (req_valid_i[idx]) begin
                winner = idx;
                found  = 1'b1;
            end
        end
    end

    // No grant while the memory output FIFO is close to full
    always_comb begin
        grant_o = '0;
        if (found && !out_almost_full_i) begin
            grant_o[winner] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            rr_ptr      <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= |grant_o;
            if (|grant_o) begin
                rr_ptr <= winner + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        winner_q <= winner;
    end

    // Granted engine's FIFO read register holds the payload by now
    assign out_payload_o = req_payload_i[winner_q];

endmodule

/* mem_response_router.sv */
`timescale 1ns/1ns

module mem_response_router (
    input  logic                             ap_clk,
    input  logic                             areset_lane_template,
    input  logic                             resp_valid_i,
    input  lane_pkg::packet_payload_u        resp_payload_i,
    output logic [lane_pkg::num_engines-1:0] engine_resp_valid_o
);

    logic [lane_pkg::num_engines-1:0] resp_onehot;

    // Engine id decode
    always_comb begin
        resp_onehot = '0;
        for (int k = 0; k < lane_pkg::num_engines; k++) begin
            if (resp_payload_i.mem.engine_id == lane_pkg::engine_id_w'(k)) begin
                resp_onehot[k] = resp_valid_i;
            end
        end
    end

    // One-cycle strobe to the owning engine only
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            engine_resp_valid_o <= '0;
        end else begin
            engine_resp_valid_o <= resp_onehot;
        end
    end

endmodule

/* lane_template.sv */
`timescale 1ns/1ns

module lane_template (
    input  logic                      ap_clk,
    input  logic                      areset_lane_template,
    input  logic                      lane_in_valid_i,
    input  lane_pkg::packet_payload_u lane_in_payload_i,
    output logic                      lane_in_full_o,
    input  logic                      mem_resp_valid_i,
    input  lane_pkg::packet_payload_u mem_resp_payload_i,
    output logic                      mem_resp_full_o,
    output logic                      lane_out_valid_o,
    output lane_pkg::packet_payload_u lane_out_payload_o,
    input  logic                      lane_out_ready_i,
    output logic                      mem_req_valid_o,
    output lane_pkg::packet_payload_u mem_req_payload_o,
    input  logic                      mem_req_ready_i,
    output logic                      done_o
);

    localparam int n = lane_pkg::num_engines;

    logic                      areset_q;
    logic                      lane_in_valid_q;
    lane_pkg::packet_payload_u lane_in_payload_q;
    logic                      mem_resp_valid_q;
    lane_pkg::packet_payload_u mem_resp_payload_q;

    logic lane_in_rd_en, lane_in_empty, lane_in_full;
    logic lane_out_rd_en, lane_out_empty, lane_out_full;
    logic mem_in_rd_en, mem_in_empty, mem_in_full, mem_in_valid;
    logic mem_out_rd_en, mem_out_empty, mem_out_full, mem_out_almost_full;

    lane_pkg::packet_payload_u mem_in_dout;
    logic                      arb_valid;
    lane_pkg::packet_payload_u arb_payload;

    // Chain index k is the input of engine k, index n feeds the output FIFO
    logic [n:0]                chain_valid;
    lane_pkg::packet_payload_u chain_payload [n+1];
    logic [n:0]                chain_almost_full;

    logic [n-1:0]              req_valid;
    lane_pkg::packet_payload_u req_payload [n];
    logic [n-1:0]              req_pop;
    logic [n-1:0]              resp_valid;
    logic [n-1:0]              idle;

    // ----------------------------------------------------------
    // Registered reset and inputs
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_q <= areset_lane_template;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_q) begin
            lane_in_valid_q  <= 1'b0;
            mem_resp_valid_q <= 1'b0;
            done_o           <= 1'b1;
        end else begin
            lane_in_valid_q  <= lane_in_valid_i;
            mem_resp_valid_q <= mem_resp_valid_i;
            done_o           <= &idle;
        end
    end

    always_ff @(posedge ap_clk) begin
        lane_in_payload_q  <= lane_in_payload_i;
        mem_resp_payload_q <= mem_resp_payload_i;
    end

    // ----------------------------------------------------------
    // Lane FIFOs and engine chain
    // ----------------------------------------------------------
    // Full is flagged early to cover the input register and the write
    assign lane_in_rd_en = ~lane_in_empty & ~chain_almost_full[0];

    sync_fifo u_lane_in_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .wr_en_i             (lane_in_valid_q),
        .din_i               (lane_in_payload_q),
        .rd_en_i             (lane_in_rd_en),
        .dout_o              (chain_payload[0]),
        .valid_o             (chain_valid[0]),
        .empty_o             (lane_in_empty),
        .full_o              (lane_in_full),
        .almost_full_o       (lane_in_full_o)
    );

    for (genvar k = 0; k < n; k++) begin : g_engine
        lane_engine #(
            .engine_index(k)
        ) u_lane_engine (
            .ap_clk              (ap_clk),
            .areset_lane_template(areset_q),
            .in_valid_i          (chain_valid[k]),
            .in_payload_i        (chain_payload[k]),
            .in_almost_full_o    (chain_almost_full[k]),
            .down_almost_full_i  (chain_almost_full[k+1]),
            .out_valid_o         (chain_valid[k+1]),
            .out_payload_o       (chain_payload[k+1]),
            .req_valid_o         (req_valid[k]),
            .req_payload_o       (req_payload[k]),
            .req_pop_i           (req_pop[k]),
            .resp_valid_i        (resp_valid[k]),
            .idle_o              (idle[k])
        );
    end

    assign lane_out_rd_en = ~lane_out_empty & lane_out_ready_i;

    sync_fifo u_lane_out_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .wr_en_i             (chain_valid[n]),
        .din_i               (chain_payload[n]),
        .rd_en_i             (lane_out_rd_en),
        .dout_o              (lane_out_payload_o),
        .valid_o             (lane_out_valid_o),
        .empty_o             (lane_out_empty),
        .full_o              (lane_out_full),
        .almost_full_o       (chain_almost_full[n])
    );

    // ----------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------
    mem_request_arbiter u_mem_request_arbiter (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .req_valid_i         (req_valid),
        .req_payload_i       (req_payload),
        .grant_o             (req_pop),
        .out_almost_full_i   (mem_out_almost_full),
        .out_valid_o         (arb_valid),
        .out_payload_o       (arb_payload)
    );

    assign mem_out_rd_en = ~mem_out_empty & mem_req_ready_i;

    sync_fifo u_mem_out_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .wr_en_i             (arb_valid),
        .din_i               (arb_payload),
        .rd_en_i             (mem_out_rd_en),
        .dout_o              (mem_req_payload_o),
        .valid_o             (mem_req_valid_o),
        .empty_o             (mem_out_empty),
        .full_o              (mem_out_full),
        .almost_full_o       (mem_out_almost_full)
    );

    // Responses never stall, the router takes one per cycle
    assign mem_in_rd_en = ~mem_in_empty;

    sync_fifo u_mem_in_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .wr_en_i             (mem_resp_valid_q),
        .din_i               (mem_resp_payload_q),
        .rd_en_i             (mem_in_rd_en),
        .dout_o              (mem_in_dout),
        .valid_o             (mem_in_valid),
        .empty_o             (mem_in_empty),
        .full_o              (mem_in_full),
        .almost_full_o       (mem_resp_full_o)
    );

    mem_response_router u_mem_response_router (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_q),
        .resp_valid_i        (mem_in_valid),
        .resp_payload_i      (mem_in_dout),
        .engine_resp_valid_o (resp_valid)
    );

endmodule

/* lane_template_checker.sv */
`timescale 1ns/1ns

module lane_template_checker (
    input logic                             ap_clk,
    input logic                             areset_lane_template,
    input logic                             lane_out_valid_i,
    input logic                             lane_out_ready_i,
    input logic                             mem_req_valid_i,
    input logic                             mem_req_ready_i,
    input logic [lane_pkg::num_engines-1:0] req_valid_i,
    input logic [lane_pkg::num_engines-1:0] grant_i,
    input logic [3:0]                       fifo_wr_i,
    input logic [3:0]                       fifo_full_i
);

    int failures = 0;

    // Output FIFO data follows a pop that ready allowed
    a_lane_out_ready : assert property (@(posedge ap_clk)
        disable iff (areset_lane_template !== 1'b0)
        lane_out_valid_i |-> $past(lane_out_ready_i))
    else begin
        failures++;
        $error("lane output valid without ready in the previous cycle");
    end

    a_mem_req_ready : assert property (@(posedge ap_clk)
        disable iff (areset_lane_template !== 1'b0)
        mem_req_valid_i |-> $past(mem_req_ready_i))
    else begin
        failures++;
        $error("memory request valid without ready in the previous cycle");
    end

    // At most one engine granted per cycle, and only one that is requesting
    a_grant_onehot : assert property (@(posedge ap_clk)
        disable iff (areset_lane_template !== 1'b0)
        $onehot0(grant_i) && ((grant_i & ~req_valid_i) == '0))
    else begin
        failures++;
        $error("arbiter grant is not one-hot or zero, or goes to an engine without a request");
    end

    a_no_write_full : assert property (@(posedge ap_clk)
        disable iff (areset_lane_template !== 1'b0)
        (fifo_wr_i & fifo_full_i) == '0)
    else begin
        failures++;
        $error("a top-level FIFO was written while full");
    end

endmodule

bind lane_template lane_template_checker u_lane_template_checker (
    .ap_clk              (ap_clk),
    .areset_lane_template(areset_q),
    .lane_out_valid_i    (lane_out_valid_o),
    .lane_out_ready_i    (lane_out_ready_i),
    .mem_req_valid_i     (mem_req_valid_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .req_valid_i         (req_valid),
    .grant_i             (req_pop),
    .fifo_wr_i           ({lane_in_valid_q, chain_valid[n], arb_valid, mem_resp_valid_q}),
    .fifo_full_i         ({lane_in_full, lane_out_full, mem_out_full, mem_in_full})
);

/* lane_template_tb.sv */
`timescale 1ns/1ns

module lane_template_tb;

    localparam int free_flow_packets = 120;
    localparam int stress_packets    = 200;
    localparam int total_packets     = free_flow_packets + stress_packets;
    localparam int timeout_cycles    = total_packets * 40 + 500;

    logic                      ap_clk;
    logic                      areset_lane_template;
    logic                      lane_in_valid_i;
    lane_pkg::packet_payload_u lane_in_payload_i;
    logic                      lane_in_full_o;
    logic                      mem_resp_valid_i;
    lane_pkg::packet_payload_u mem_resp_payload_i;
    logic                      mem_resp_full_o;
    logic                      lane_out_valid_o;
    lane_pkg::packet_payload_u lane_out_payload_o;
    logic                      lane_out_ready_i;
    logic                      mem_req_valid_o;
    lane_pkg::packet_payload_u mem_req_payload_o;
    logic                      mem_req_ready_i;
    logic                      done_o;

    // Expected lane outputs in order, requests per engine in order
    lane_pkg::packet_payload_u exp_lane [$];
    lane_pkg::packet_payload_u exp_req [lane_pkg::num_engines][$];
    // Memory model backlog
    lane_pkg::packet_payload_u resp_payload_q [$];
    int                        resp_due_q [$];
    int                        awaiting_resp;
    int                        cycle;
    int                        checks;
    int                        value_errors;
    int                        other_errors;
    logic [31:0]               rng_state;
    string                     test_name;

    lane_template u_lane_template (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .lane_in_valid_i     (lane_in_valid_i),
        .lane_in_payload_i   (lane_in_payload_i),
        .lane_in_full_o      (lane_in_full_o),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_payload_i  (mem_resp_payload_i),
        .mem_resp_full_o     (mem_resp_full_o),
        .lane_out_valid_o    (lane_out_valid_o),
        .lane_out_payload_o  (lane_out_payload_o),
        .lane_out_ready_i    (lane_out_ready_i),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_payload_o   (mem_req_payload_o),
        .mem_req_ready_i     (mem_req_ready_i),
        .done_o              (done_o)
    );

    always #4 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------------------------
    // Random numbers and reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = lcg_step(rng_state);
        value     = rng_state;
    endtask

    // Every engine on the chain adds one hop, nothing else changes
    function automatic lane_pkg::packet_payload_u expected_lane_out(
        input lane_pkg::packet_payload_u pkt
    );
        lane_pkg::packet_payload_u result;
        result          = pkt;
        result.lane.hop = pkt.lane.hop + lane_pkg::hop_w'(lane_pkg::num_engines);
        return result;
    endfunction

    // Target engine asks for the packet's data as an address
    function automatic lane_pkg::packet_payload_u expected_request(
        input lane_pkg::packet_payload_u pkt
    );
        lane_pkg::packet_payload_u result;
        result.mem.engine_id = pkt.lane.target;
        result.mem.spare     = '0;
        result.mem.addr      = pkt.lane.data;
        return result;
    endfunction

    function automatic int pending_requests();
        int total;
        total = 0;
        for (int e = 0; e < lane_pkg::num_engines; e++) begin
            total += exp_req[e].size();
        end
        return total;
    endfunction

    task automatic check_value(input string what,
                               input logic [lane_pkg::payload_w-1:0] expected,
                               input logic [lane_pkg::payload_w-1:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors,
                 u_lane_template.u_lane_template_checker.failures);
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    task automatic set_ready(input bit random_ready);
        logic [31:0] r;
        if (random_ready) begin
            next_random(r);
            lane_out_ready_i <= r[31];
            mem_req_ready_i  <= r[30] | r[29];
        end else begin
            lane_out_ready_i <= 1'b1;
            mem_req_ready_i  <= 1'b1;
        end
    endtask

    task automatic send_packets(input int count, input bit random_ready);
        lane_pkg::packet_payload_u pkt;
        logic [31:0]               r;
        logic [31:0]               data;
        int                        sent;
        sent = 0;
        while (sent < count) begin
            @(posedge ap_clk);
            set_ready(random_ready);
            next_random(r);
            if (!lane_in_full_o && (!random_ready || r[31])) begin
                next_random(data);
                pkt             = '0;
                pkt.lane.target = r[27:26];
                pkt.lane.data   = data;
                exp_lane.push_back(expected_lane_out(pkt));
                exp_req[pkt.lane.target].push_back(expected_request(pkt));
                lane_in_valid_i   <= 1'b1;
                lane_in_payload_i <= pkt;
                sent++;
            end else begin
                lane_in_valid_i <= 1'b0;
            end
        end
        @(posedge ap_clk);
        lane_in_valid_i <= 1'b0;
    endtask

    // Run until every packet, request and response has gone through
    task automatic drain_lane(input bit random_ready);
        while (exp_lane.size() != 0 || pending_requests() != 0 ||
               resp_payload_q.size() != 0 || done_o !== 1'b1) begin
            @(posedge ap_clk);
            set_ready(random_ready);
        end
    endtask

    task automatic check_idle();
        @(negedge ap_clk);
        check_value("done_o", 1'b1, done_o);
        check_value("lane_out_valid_o", 1'b0, lane_out_valid_o);
        check_value("mem_req_valid_o", 1'b0, mem_req_valid_o);
    endtask

    // ----------------------------------------------------------
    // Memory model, answers in order after a random delay
    // ----------------------------------------------------------
    always @(posedge ap_clk) begin
        if (areset_lane_template) begin
            mem_resp_valid_i <= 1'b0;
        end else if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle && !mem_resp_full_o) begin
            mem_resp_valid_i   <= 1'b1;
            mem_resp_payload_i <= resp_payload_q.pop_front();
            void'(resp_due_q.pop_front());
            awaiting_resp--;
        end else begin
            mem_resp_valid_i <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Compare process
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        lane_pkg::packet_payload_u head;
        logic [31:0]               r;
        int                        engine;
        if (areset_lane_template === 1'b0) begin
            if (lane_out_valid_o === 1'b1) begin
                if (exp_lane.size() == 0) begin
                    other_errors++;
                    $display("%s: lane output %h appeared with no packet in flight",
                             test_name, lane_out_payload_o);
                end else begin
                    head = exp_lane.pop_front();
                    check_value("lane output", head, lane_out_payload_o);
                end
            end
            if (mem_req_valid_o === 1'b1) begin
                engine = int'(mem_req_payload_o.mem.engine_id);
                if (exp_req[engine].size() == 0) begin
                    other_errors++;
                    $display("%s: memory request %h was not expected from engine %0d",
                             test_name, mem_req_payload_o, engine);
                end else begin
                    head = exp_req[engine].pop_front();
                    check_value("memory request", head, mem_req_payload_o);
                end
                next_random(r);
                resp_payload_q.push_back(mem_req_payload_o);
                resp_due_q.push_back(cycle + 1 + int'(r[31:29]));
                awaiting_resp++;
            end
            if (awaiting_resp > 0 && done_o !== 1'b0) begin
                other_errors++;
                $display("%s: done_o is high while %0d requests wait for a response",
                         test_name, awaiting_resp);
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge ap_clk);
        $display("timeout: the lane did not finish within %0d cycles", timeout_cycles);
        print_counts();
        $display("TB FAILED");
        $finish;
    end

    initial begin
        ap_clk               = 1'b0;
        cycle                = 0;
        checks               = 0;
        value_errors         = 0;
        other_errors         = 0;
        awaiting_resp        = 0;
        rng_state            = 32'h8e0c_636a;
        areset_lane_template = 1'b1;
        lane_in_valid_i      = 1'b0;
        lane_in_payload_i    = '0;
        mem_resp_valid_i     = 1'b0;
        mem_resp_payload_i   = '0;
        lane_out_ready_i     = 1'b1;
        mem_req_ready_i      = 1'b1;
        test_name            = "reset";
        repeat (4) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
        repeat (2) @(posedge ap_clk);
        check_idle();
        check_value("lane_in_full_o", 1'b0, lane_in_full_o);
        check_value("mem_resp_full_o", 1'b0, mem_resp_full_o);

        test_name = "free_flow";
        send_packets(free_flow_packets, 1'b0);
        drain_lane(1'b0);
        check_idle();

        test_name = "backpressure";
        send_packets(stress_packets, 1'b1);
        drain_lane(1'b1);
        check_idle();

        print_counts();
        if (value_errors + other_errors +
            u_lane_template.u_lane_template_checker.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
lane_pkg.sv
sync_fifo.sv
lane_engine.sv
mem_request_arbiter.sv
mem_response_router.sv
lane_template.sv
lane_template_checker.sv
lane_template_tb.sv

/* Bender.yml */
package:
  name: lane_template

sources:
  - lane_pkg.sv
  - sync_fifo.sv
  - lane_engine.sv
  - mem_request_arbiter.sv
  - mem_response_router.sv
  - lane_template.sv
  - target: test
    files:
      - lane_template_checker.sv
      - lane_template_tb.sv
